// File: Bender.yml
package:
  name: rv_int_pipe

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decode.sv
  - hdl/rv_execute.sv
  - hdl/rv_result.sv
  - hdl/rv_int_pipe.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_rv_int_pipe.sv

// File: hdl/rv_decode.sv
// ========================================
// rv_decode
// input stage register, RV64 integer
// decode and operand selection
// ========================================

`timescale 1ns/1ps

module rv_decode (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  input  logic [rv_pkg::xlen-1:0]         in_pc,
  input  rv_pkg::inst_u                   in_inst,
  input  logic [rv_pkg::xlen-1:0]         in_rs1_data,
  input  logic [rv_pkg::xlen-1:0]         in_rs2_data,
  output logic                            in_ready,
  output logic                            dec_valid,
  input  logic                            dec_ready,
  output rv_pkg::alu_op_e                 dec_op,
  output logic                            dec_word,
  output logic [rv_pkg::xlen-1:0]         dec_a,
  output logic [rv_pkg::xlen-1:0]         dec_b,
  output logic [rv_pkg::reg_addr_w-1:0]   dec_rd,
  output logic                            dec_we,
  output logic                            dec_illegal,
  output logic [rv_pkg::xlen-1:0]         dec_pc
);
  import rv_pkg::*;

  logic            valid_q;
  logic [xlen-1:0] pc_q;
  inst_u           inst_q;
  logic [xlen-1:0] rs1_q;
  logic [xlen-1:0] rs2_q;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [5:0]      funct6;
  logic            r_std;
  logic            r_alt;
  logic            i_std;
  logic            i_alt;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic            legal;

  // take new entry when empty or when the held one leaves
  assign in_ready = !valid_q || dec_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      pc_q   <= in_pc;
      inst_q <= in_inst;
      rs1_q  <= in_rs1_data;
      rs2_q  <= in_rs2_data;
    end
  end

  assign opcode = inst_q.r_fmt.opcode;
  assign funct3 = inst_q.r_fmt.funct3;
  assign funct7 = inst_q.r_fmt.funct7;
  assign funct6 = inst_q.i_fmt.imm12[11:6];

  assign imm_i = {{(xlen - 12){inst_q.i_fmt.imm12[11]}}, inst_q.i_fmt.imm12};
  assign imm_u = {{(xlen - 32){inst_q.u_fmt.imm20[19]}}, inst_q.u_fmt.imm20, 12'b0};

  assign dec_word = (opcode == op_reg_32) || (opcode == op_imm_32);

  assign r_std = (funct7 == 7'h00);
  assign r_alt = (funct7 == funct7_alt);
  // word shifts only take a 5-bit shamt
  assign i_std = (funct6 == 6'h00) && !(dec_word && inst_q.i_fmt.imm12[5]);
  assign i_alt = (funct6 == funct6_alt) && !(dec_word && inst_q.i_fmt.imm12[5]);

  always_comb begin
    dec_op = alu_add;
    dec_a  = rs1_q;
    dec_b  = rs2_q;
    legal  = 1'b0;
    case (opcode)
      op_reg, op_reg_32: begin
        case (funct3)
          3'd0: begin
            dec_op = r_alt ? alu_sub : alu_add;
            legal  = r_std || r_alt;
          end
          3'd1: begin
            dec_op = alu_sll;
            legal  = r_std;
          end
          3'd2: begin
            dec_op = alu_slt;
            legal  = r_std && !dec_word;
          end
          3'd3: begin
            dec_op = alu_sltu;
            legal  = r_std && !dec_word;
          end
          3'd4: begin
            dec_op = alu_xor;
            legal  = r_std && !dec_word;
          end
          3'd5: begin
            dec_op = r_alt ? alu_sra : alu_srl;
            legal  = r_std || r_alt;
          end
          3'd6: begin
            dec_op = alu_or;
            legal  = r_std && !dec_word;
          end
          default: begin
            dec_op = alu_and;
            legal  = r_std && !dec_word;
          end
        endcase
      end
      op_imm, op_imm_32: begin
        dec_b = imm_i;
        case (funct3)
          3'd0: begin
            dec_op = alu_add;
            legal  = 1'b1;
          end
          3'd1: begin
            dec_op = alu_sll;
            legal  = i_std;
          end
          3'd2: begin
            dec_op = alu_slt;
            legal  = !dec_word;
          end
          3'd3: begin
            dec_op = alu_sltu;
            legal  = !dec_word;
          end
          3'd4: begin
            dec_op = alu_xor;
            legal  = !dec_word;
          end
          3'd5: begin
            dec_op = i_alt ? alu_sra : alu_srl;
            legal  = i_std || i_alt;
          end
          3'd6: begin
            dec_op = alu_or;
            legal  = !dec_word;
          end
          default: begin
            dec_op = alu_and;
            legal  = !dec_word;
          end
        endcase
      end
      op_lui: begin
        dec_op = alu_pass_b;
        dec_a  = '0;
        dec_b  = imm_u;
        legal  = 1'b1;
      end
      op_auipc: begin
        dec_a = pc_q;
        dec_b = imm_u;
        legal = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  assign dec_valid   = valid_q;
  assign dec_rd      = inst_q.r_fmt.rd;
  assign dec_we      = legal;
  assign dec_illegal = !legal;
  assign dec_pc      = pc_q;

  // a stalled offer must be held by the sender
  a_in_pc_stable: assert property (@(posedge clk) disable iff (rst)
    in_valid && !in_ready |=> $stable(in_pc));

endmodule

// File: hdl/rv_execute.sv
// ========================================
// rv_execute
// 64-bit and word ALU with its stage
// register
// ========================================

`timescale 1ns/1ps

module rv_execute (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            dec_valid,
  output logic                            dec_ready,
  input  rv_pkg::alu_op_e                 dec_op,
  input  logic                            dec_word,
  input  logic [rv_pkg::xlen-1:0]         dec_a,
  input  logic [rv_pkg::xlen-1:0]         dec_b,
  input  logic [rv_pkg::reg_addr_w-1:0]   dec_rd,
  input  logic                            dec_we,
  input  logic                            dec_illegal,
  input  logic [rv_pkg::xlen-1:0]         dec_pc,
  output logic                            exe_valid,
  input  logic                            exe_ready,
  output logic [rv_pkg::reg_addr_w-1:0]   exe_rd,
  output logic [rv_pkg::xlen-1:0]         exe_data,
  output logic                            exe_we,
  output logic                            exe_illegal,
  output logic [rv_pkg::xlen-1:0]         exe_pc
);
  import rv_pkg::*;

  logic [5:0]      shamt;
  logic [xlen-1:0] a_srl;
  logic [xlen-1:0] a_sra;
  logic [xlen-1:0] raw;
  logic [xlen-1:0] alu_res;

  assign dec_ready = !exe_valid || exe_ready;

  // word ops shift by 5 bits and use the low word of a
  assign shamt = dec_word ? {1'b0, dec_b[4:0]} : dec_b[5:0];
  assign a_srl = dec_word ? {{(xlen - word_len){1'b0}}, dec_a[word_len-1:0]} : dec_a;
  assign a_sra = dec_word ? {{(xlen - word_len){dec_a[word_len-1]}}, dec_a[word_len-1:0]}
                          : dec_a;

  always_comb begin
    case (dec_op)
      alu_add:    raw = dec_a + dec_b;
      alu_sub:    raw = dec_a - dec_b;
      alu_sll:    raw = dec_a << shamt;
      alu_slt:    raw = {{(xlen - 1){1'b0}}, $signed(dec_a) < $signed(dec_b)};
      alu_sltu:   raw = {{(xlen - 1){1'b0}}, dec_a < dec_b};
      alu_xor:    raw = dec_a ^ dec_b;
      alu_srl:    raw = a_srl >> shamt;
      alu_sra:    raw = $signed(a_sra) >>> shamt;
      alu_or:     raw = dec_a | dec_b;
      alu_and:    raw = dec_a & dec_b;
      alu_pass_b: raw = dec_b;
      default:    raw = '0;
    endcase
  end

  assign alu_res = dec_word ? {{(xlen - word_len){raw[word_len-1]}}, raw[word_len-1:0]} : raw;

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
    end else if (dec_ready) begin
      exe_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid && dec_ready) begin
      exe_rd      <= dec_rd;
      exe_data    <= dec_illegal ? '0 : alu_res;
      exe_we      <= dec_we;
      exe_illegal <= dec_illegal;
      exe_pc      <= dec_pc;
    end
  end

  a_exe_valid_known: assert property (@(posedge clk) !rst |-> !$isunknown(exe_valid));

endmodule

// File: hdl/rv_int_pipe.sv
// ========================================
// rv_int_pipe
// three-stage RV64 integer pipeline top
// ========================================

`timescale 1ns/1ps

module rv_int_pipe #(
  parameter int result_depth = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [rv_pkg::xlen-1:0]         in_pc,
  input  rv_pkg::inst_u                   in_inst,
  input  logic [rv_pkg::xlen-1:0]         in_rs1_data,
  input  logic [rv_pkg::xlen-1:0]         in_rs2_data,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [rv_pkg::xlen-1:0]         out_pc,
  output logic [rv_pkg::reg_addr_w-1:0]   out_rd_addr,
  output logic [rv_pkg::xlen-1:0]         out_rd_data,
  output logic                            out_rd_we,
  output logic                            out_illegal
);
  import rv_pkg::*;

  // decode to execute
  logic                  dec_valid;
  logic                  dec_ready;
  alu_op_e               dec_op;
  logic                  dec_word;
  logic [xlen-1:0]       dec_a;
  logic [xlen-1:0]       dec_b;
  logic [reg_addr_w-1:0] dec_rd;
  logic                  dec_we;
  logic                  dec_illegal;
  logic [xlen-1:0]       dec_pc;

  // execute to result
  logic                  exe_valid;
  logic                  exe_ready;
  logic [reg_addr_w-1:0] exe_rd;
  logic [xlen-1:0]       exe_data;
  logic                  exe_we;
  logic                  exe_illegal;
  logic [xlen-1:0]       exe_pc;

  rv_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_pc       (in_pc),
    .in_inst     (in_inst),
    .in_rs1_data (in_rs1_data),
    .in_rs2_data (in_rs2_data),
    .in_ready    (in_ready),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_op      (dec_op),
    .dec_word    (dec_word),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_rd      (dec_rd),
    .dec_we      (dec_we),
    .dec_illegal (dec_illegal),
    .dec_pc      (dec_pc)
  );

  rv_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_op      (dec_op),
    .dec_word    (dec_word),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_rd      (dec_rd),
    .dec_we      (dec_we),
    .dec_illegal (dec_illegal),
    .dec_pc      (dec_pc),
    .exe_valid   (exe_valid),
    .exe_ready   (exe_ready),
    .exe_rd      (exe_rd),
    .exe_data    (exe_data),
    .exe_we      (exe_we),
    .exe_illegal (exe_illegal),
    .exe_pc      (exe_pc)
  );

  rv_result #(
    .result_depth (result_depth)
  ) u_result (
    .clk         (clk),
    .rst         (rst),
    .exe_valid   (exe_valid),
    .exe_ready   (exe_ready),
    .exe_rd      (exe_rd),
    .exe_data    (exe_data),
    .exe_we      (exe_we),
    .exe_illegal (exe_illegal),
    .exe_pc      (exe_pc),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_pc      (out_pc),
    .out_rd_addr (out_rd_addr),
    .out_rd_data (out_rd_data),
    .out_rd_we   (out_rd_we),
    .out_illegal (out_illegal)
  );

endmodule

// File: hdl/rv_pkg.sv
// ========================================
// rv_pkg
// shared widths, RV64 opcode and funct
// constants, ALU operation codes and the
// instruction word formats
// ========================================

package rv_pkg;

  parameter int xlen       = 64;
  parameter int word_len   = 32;
  parameter int reg_addr_w = 5;

  // major opcodes of the supported groups
  parameter logic [6:0] op_imm    = 7'h13;
  parameter logic [6:0] op_imm_32 = 7'h1b;
  parameter logic [6:0] op_reg    = 7'h33;
  parameter logic [6:0] op_reg_32 = 7'h3b;
  parameter logic [6:0] op_lui    = 7'h37;
  parameter logic [6:0] op_auipc  = 7'h17;

  // sub / sra select
  parameter logic [6:0] funct7_alt = 7'h20;
  // srai select, upper bits of imm12
  parameter logic [5:0] funct6_alt = 6'h10;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // one 32-bit word, three field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
  } inst_u;

endpackage

// File: hdl/rv_result.sv
// ========================================
// rv_result
// in-order result queue, drops x0 writes
// ========================================

`timescale 1ns/1ps

module rv_result #(
  parameter int result_depth = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            exe_valid,
  output logic                            exe_ready,
  input  logic [rv_pkg::reg_addr_w-1:0]   exe_rd,
  input  logic [rv_pkg::xlen-1:0]         exe_data,
  input  logic                            exe_we,
  input  logic                            exe_illegal,
  input  logic [rv_pkg::xlen-1:0]         exe_pc,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [rv_pkg::xlen-1:0]         out_pc,
  output logic [rv_pkg::reg_addr_w-1:0]   out_rd_addr,
  output logic [rv_pkg::xlen-1:0]         out_rd_data,
  output logic                            out_rd_we,
  output logic                            out_illegal
);
  import rv_pkg::*;

  localparam int ptr_w = (result_depth > 1) ? $clog2(result_depth) : 1;
  localparam int cnt_w = $clog2(result_depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(result_depth - 1);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(result_depth);

  logic [xlen-1:0]       pc_mem   [result_depth];
  logic [reg_addr_w-1:0] rd_mem   [result_depth];
  logic [xlen-1:0]       data_mem [result_depth];
  logic                  we_mem   [result_depth];
  logic                  ill_mem  [result_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             push;
  logic             pop;
  logic             rd_zero;

  assign full      = (count == full_cnt);
  assign pop       = out_valid && out_ready;
  assign exe_ready = !full || pop;
  assign push      = exe_valid && exe_ready;
  assign rd_zero   = (exe_rd == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // x0 is never written back
  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr]   <= exe_pc;
      rd_mem[wr_ptr]   <= exe_rd;
      data_mem[wr_ptr] <= rd_zero ? '0 : exe_data;
      we_mem[wr_ptr]   <= exe_we && !rd_zero;
      ill_mem[wr_ptr]  <= exe_illegal;
    end
  end

  assign out_valid   = (count != '0);
  assign out_pc      = pc_mem[rd_ptr];
  assign out_rd_addr = rd_mem[rd_ptr];
  assign out_rd_data = data_mem[rd_ptr];
  assign out_rd_we   = we_mem[rd_ptr];
  assign out_illegal = ill_mem[rd_ptr];

  // full queue without a pop must not take an entry
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    full && !pop |=> full && $stable(wr_ptr));

endmodule

// File: tb.f
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_int_pipe.sv
test/tb_clock.sv
test/tb_rv_int_pipe.sv

// File: test/tb_clock.sv
// ========================================
// tb_clock
// testbench clock and synchronous reset
// ========================================

`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

// File: test/tb_rv_int_pipe.sv
// ========================================
// tb_rv_int_pipe
// directed tests for the RV64 integer
// pipeline with an in-order reference model
// ========================================

`timescale 1ns/1ps

module tb_rv_int_pipe;
  import rv_pkg::*;

  localparam int timeout_cycles = 200;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic                  in_ready;
  logic [xlen-1:0]       in_pc;
  inst_u                 in_inst;
  logic [xlen-1:0]       in_rs1_data;
  logic [xlen-1:0]       in_rs2_data;
  logic                  out_valid;
  logic                  out_ready;
  logic [xlen-1:0]       out_pc;
  logic [reg_addr_w-1:0] out_rd_addr;
  logic [xlen-1:0]       out_rd_data;
  logic                  out_rd_we;
  logic                  out_illegal;

  // one batch of instructions and its expected results
  logic [31:0] b_inst [16];
  logic [63:0] b_pc   [16];
  logic [63:0] b_rs1  [16];
  logic [63:0] b_rs2  [16];
  logic [63:0] b_data [16];
  logic        b_we   [16];
  logic        b_ill  [16];
  int          b_acc  [16];
  int          n_items;
  int          n_accepted;

  int cycle;
  int seed;
  int pass_count;
  int fail_count;
  int test_fails;

  tb_clock #(.period_ns(40), .reset_cycles(10)) u_clock (.clk(clk), .rst(rst));

  rv_int_pipe #(.result_depth(2)) dut0 (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_pc       (in_pc),
    .in_inst     (in_inst),
    .in_rs1_data (in_rs1_data),
    .in_rs2_data (in_rs2_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_pc      (out_pc),
    .out_rd_addr (out_rd_addr),
    .out_rd_data (out_rd_data),
    .out_rd_we   (out_rd_we),
    .out_illegal (out_illegal)
  );

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] r_inst(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {f7, rs2, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd2, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_inst(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] got_v);
    assert (got_v === exp_v) begin
      pass_count++;
    end else begin
      $display("error %s expected %h actual %h", name, exp_v, got_v);
      fail_count++;
    end
  endtask

  // RV64I rules applied to the raw instruction fields
  task automatic ref_model(input logic [31:0] inst, input logic [63:0] pc,
                           input logic [63:0] rs1, input logic [63:0] rs2,
                           output logic [63:0] data, output logic we, output logic ill);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] aw;
    logic [63:0] r;
    logic [63:0] upper;
    logic [5:0]  sh;
    logic        is_reg;
    logic        is_imm;
    logic        word;
    logic        alt;
    logic        ok;
    opc    = inst[6:0];
    f3     = inst[14:12];
    f7     = inst[31:25];
    is_reg = (opc == 7'h33) || (opc == 7'h3b);
    is_imm = (opc == 7'h13) || (opc == 7'h1b);
    word   = (opc == 7'h3b) || (opc == 7'h1b);
    upper  = {{32{inst[31]}}, inst[31:12], 12'h000};
    a      = rs1;
    b      = rs2;
    alt    = 1'b0;
    ok     = 1'b1;
    r      = '0;
    if (is_reg || is_imm) begin
      if (is_reg) begin
        alt = (f7 == 7'h20);
        ok  = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
      end else begin
        b = {{52{inst[31]}}, inst[31:20]};
        if (f3 == 3'd1) ok = (inst[31:26] == 6'h00);
        if (f3 == 3'd5) begin
          alt = (inst[31:26] == 6'h10);
          ok  = (inst[31:26] == 6'h00) || alt;
        end
        if (word && (f3 == 3'd1 || f3 == 3'd5) && inst[25]) ok = 1'b0;
      end
      if (word && f3 != 3'd0 && f3 != 3'd1 && f3 != 3'd5) ok = 1'b0;
      sh = word ? {1'b0, b[4:0]} : b[5:0];
      if (word) begin
        aw = alt ? {{32{a[31]}}, a[31:0]} : {32'h0, a[31:0]};
      end else begin
        aw = a;
      end
      case (f3)
        3'd0: r = (is_reg && alt) ? a - b : a + b;
        3'd1: r = a << sh;
        3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: r = (a < b) ? 64'd1 : 64'd0;
        3'd4: r = a ^ b;
        3'd5: r = alt ? 64'($signed(aw) >>> sh) : aw >> sh;
        3'd6: r = a | b;
        default: r = a & b;
      endcase
      if (word) r = {{32{r[31]}}, r[31:0]};
    end else if (opc == 7'h37) begin
      r = upper;
    end else if (opc == 7'h17) begin
      r = pc + upper;
    end else begin
      ok = 1'b0;
    end
    ill  = !ok;
    we   = ok && (inst[11:7] != 5'd0);
    data = we ? r : 64'h0;
  endtask

  task automatic add_inst(input logic [31:0] inst, input logic [63:0] rs1,
                          input logic [63:0] rs2);
    b_inst[n_items] = inst;
    b_pc[n_items]   = 64'h1000 + 64'(4 * n_items);
    b_rs1[n_items]  = rs1;
    b_rs2[n_items]  = rs2;
    ref_model(inst, b_pc[n_items], rs1, rs2, b_data[n_items], b_we[n_items],
              b_ill[n_items]);
    n_items++;
  endtask

  task automatic send_batch();
    int  i;
    int  waited;
    bit  accepted;
    bit  stuck;
    stuck = 0;
    for (i = 0; i < n_items && !stuck; i++) begin
      in_valid    = 1'b1;
      in_pc       = b_pc[i];
      in_inst     = b_inst[i];
      in_rs1_data = b_rs1[i];
      in_rs2_data = b_rs2[i];
      accepted    = 0;
      waited      = 0;
      while (!accepted && waited < timeout_cycles) begin
        @(negedge clk);
        if (in_ready) accepted = 1;
        else waited++;
      end
      if (!accepted) begin
        $display("timeout waiting for in_ready on instruction %0d", i);
        fail_count++;
        stuck = 1;
      end else begin
        b_acc[i] = cycle + 1;
        n_accepted++;
        @(posedge clk);
        #2;
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic collect_batch(input bit check_lat);
    int i;
    int waited;
    bit got;
    bit stuck;
    stuck = 0;
    for (i = 0; i < n_items && !stuck; i++) begin
      got    = 0;
      waited = 0;
      while (!got && waited < timeout_cycles) begin
        @(negedge clk);
        if (out_valid && out_ready) got = 1;
        else waited++;
      end
      if (!got) begin
        $display("timeout waiting for result %0d of %0d", i, n_items);
        fail_count++;
        stuck = 1;
      end else begin
        check_val("out_pc", b_pc[i], out_pc);
        check_val("out_rd_addr", 64'(b_inst[i][11:7]), 64'(out_rd_addr));
        check_val("out_rd_data", b_data[i], out_rd_data);
        check_val("out_rd_we", 64'(b_we[i]), 64'(out_rd_we));
        check_val("out_illegal", 64'(b_ill[i]), 64'(out_illegal));
        if (check_lat) check_val("latency", 64'd2, 64'(cycle - b_acc[i]));
      end
    end
  endtask

  task automatic run_batch();
    fork
      send_batch();
      collect_batch(1'b1);
    join
  endtask

  task automatic start_test();
    @(posedge clk);
    #2;
    n_items    = 0;
    n_accepted = 0;
    test_fails = fail_count;
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, fail_count - test_fails);
  endtask

  task automatic reset_state_test();
    int waited;
    start_test();
    waited = 0;
    while (rst && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (rst) begin
      $display("timeout waiting for reset to be released");
      fail_count++;
    end
    @(negedge clk);
    check_val("out_valid", 64'd0, 64'(out_valid));
    check_val("in_ready", 64'd1, 64'(in_ready));
    end_test("reset_state");
  endtask

  task automatic reg_ops_test();
    int i;
    start_test();
    for (i = 0; i < 8; i++) begin
      add_inst(r_inst(7'h00, 5'd3, 3'(i), 5'(i + 1), op_reg), rand64(), rand64());
    end
    add_inst(r_inst(7'h20, 5'd3, 3'd0, 5'd10, op_reg), rand64(), rand64());
    // negative rs1 so the arithmetic shift shows
    add_inst(r_inst(7'h20, 5'd3, 3'd5, 5'd11, op_reg), rand64() | 64'h8000_0000_0000_0000,
             rand64());
    run_batch();
    end_test("reg_ops");
  endtask

  task automatic imm_ops_test();
    start_test();
    add_inst(i_inst(12'h800, 3'd0, 5'd1, op_imm), rand64(), 64'h0);
    add_inst(i_inst(12'hfff, 3'd2, 5'd2, op_imm), 64'h0, 64'h0);
    add_inst(i_inst(12'hfff, 3'd3, 5'd3, op_imm), rand64(), 64'h0);
    add_inst(i_inst(12'hf0f, 3'd4, 5'd4, op_imm), rand64(), 64'h0);
    add_inst(i_inst(12'h0f0, 3'd6, 5'd5, op_imm), rand64(), 64'h0);
    add_inst(i_inst(12'h8ff, 3'd7, 5'd6, op_imm), rand64(), 64'h0);
    add_inst(i_inst(12'h028, 3'd1, 5'd7, op_imm), rand64(), 64'h0);
    add_inst(i_inst(12'h021, 3'd5, 5'd8, op_imm), 64'hf000_0000_0000_0000, 64'h0);
    add_inst(i_inst(12'h421, 3'd5, 5'd9, op_imm), 64'hf000_0000_0000_0000, 64'h0);
    add_inst(u_inst(20'h80000, 5'd10, op_lui), rand64(), 64'h0);
    add_inst(u_inst(20'h12345, 5'd11, op_lui), rand64(), 64'h0);
    add_inst(u_inst(20'hfffff, 5'd12, op_auipc), rand64(), 64'h0);
    run_batch();
    end_test("imm_ops");
  endtask

  task automatic word_ops_test();
    start_test();
    add_inst(r_inst(7'h00, 5'd3, 3'd0, 5'd1, op_reg_32), 64'h7fff_ffff, 64'h1);
    // overflow into bit 31 comes back sign-extended
    b_data[0] = 64'hffff_ffff_8000_0000;
    add_inst(r_inst(7'h20, 5'd3, 3'd0, 5'd2, op_reg_32), rand64(), rand64());
    add_inst(r_inst(7'h00, 5'd3, 3'd1, 5'd3, op_reg_32), rand64(), 64'h3f);
    add_inst(r_inst(7'h00, 5'd3, 3'd5, 5'd4, op_reg_32), 64'hdead_beef_8000_0000, 64'h24);
    add_inst(r_inst(7'h20, 5'd3, 3'd5, 5'd5, op_reg_32), 64'h1234_5678_8000_0000, 64'h24);
    add_inst(i_inst(12'h800, 3'd0, 5'd6, op_imm_32), rand64(), 64'h0);
    add_inst(i_inst(12'h01f, 3'd1, 5'd7, op_imm_32), rand64(), 64'h0);
    add_inst(i_inst(12'h004, 3'd5, 5'd8, op_imm_32), 64'hdead_beef_8000_0000, 64'h0);
    add_inst(i_inst(12'h404, 3'd5, 5'd9, op_imm_32), 64'hdead_beef_8000_0000, 64'h0);
    run_batch();
    end_test("word_ops");
  endtask

  task automatic illegal_x0_test();
    start_test();
    add_inst({25'h1abcd, 7'h7f}, rand64(), rand64());
    add_inst({25'h0000f, 7'h03}, rand64(), rand64());
    add_inst(r_inst(7'h01, 5'd3, 3'd0, 5'd4, op_reg), rand64(), rand64());
    add_inst(r_inst(7'h00, 5'd3, 3'd0, 5'd0, op_reg), rand64(), rand64());
    run_batch();
    end_test("illegal_x0");
  endtask

  task automatic back_pressure_test();
    int i;
    int waited;
    bit stalled;
    start_test();
    for (i = 0; i < 8; i++) begin
      add_inst(i_inst(12'(i * 37), 3'd0, 5'(i + 1), op_imm), rand64(), 64'h0);
    end
    out_ready = 1'b0;
    fork
      send_batch();
      begin
        stalled = 0;
        waited  = 0;
        while (!stalled && waited < timeout_cycles) begin
          @(negedge clk);
          if (in_valid && !in_ready) stalled = 1;
          else waited++;
        end
        assert (stalled && n_accepted <= 4) begin
          pass_count++;
        end else begin
          $display("in_ready did not drop in time, %0d instructions accepted", n_accepted);
          fail_count++;
        end
        repeat (3) @(posedge clk);
        #2;
        out_ready = 1'b1;
        collect_batch(1'b0);
      end
    join
    // second half streams with out_ready high
    @(posedge clk);
    #2;
    n_items    = 0;
    n_accepted = 0;
    for (i = 0; i < 8; i++) begin
      add_inst(r_inst(7'h00, 5'd3, 3'(i), 5'(i + 20), op_reg), rand64(), rand64());
    end
    run_batch();
    end_test("back_pressure");
  endtask

  initial begin
    in_valid    = 1'b0;
    in_pc       = '0;
    in_inst     = '0;
    in_rs1_data = '0;
    in_rs2_data = '0;
    out_ready   = 1'b0;
    cycle       = 0;
    seed        = 32'h91de;
    pass_count  = 0;
    fail_count  = 0;
    n_items     = 0;
    n_accepted  = 0;

    reset_state_test();
    @(posedge clk);
    #2;
    out_ready = 1'b1;
    reg_ops_test();
    imm_ops_test();
    word_ops_test();
    illegal_x0_test();
    back_pressure_test();

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
